/* verilog/udp_params.svh */
// Port table size, client latency, header length, default ports and total latency
`ifndef UDP_PARAMS_SVH
`define UDP_PARAMS_SVH

// Number of port table slots
`define UDP_N_SLOTS 4
// Client pipeline depth, at least 1
`define UDP_N_LAT 3
// Header bytes, also the framer window depth
`define UDP_HDR_LEN 4

// Port table contents after reset
`define UDP_PORT0 16'd7
`define UDP_PORT1 16'd801
`define UDP_PORT2 16'd802
`define UDP_PORT3 16'd803

// rxd to txd: parser, match, client, 4-deep framer window
`define UDP_LAT (`UDP_N_LAT + 6)

`endif

/* verilog/udp_pkg.sv */
// Beat and configuration structs, slot index and transform enum
`include "udp_params.svh"

package udp_pkg;

	// Index into the port table
	typedef logic [$clog2(`UDP_N_SLOTS)-1:0] slot_t;

	// Slot number picks the payload transform
	typedef enum slot_t {
		XF_ECHO = 2'd0,
		XF_INV = 2'd1,
		XF_INC = 2'd2,
		XF_REV = 2'd3
	} xform_e;

	// One byte in flight through the stages
	typedef struct packed {
		logic valid;
		logic [7:0] data;
		logic sof;
		// Saturates at 4, the payload marker
		logic [2:0] pos;
		logic hit;
		slot_t slot;
	} beat_t;

	// Port table write
	typedef struct packed {
		logic stb;
		slot_t addr;
		logic [15:0] port;
	} cfg_t;

endpackage

/* verilog/beat_delay.sv */
// Fixed-depth register chain for any packed payload type
`timescale 1ns/1ps

module beat_delay #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 1
) (
	input clk,
	input arst_n,
	input payload_t d,
	output payload_t q
);

	payload_t stage [DEPTH];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DEPTH; i++)
				stage[i] <= '0;
		end else begin
			stage[0] <= d;
			// Shift one register per cycle
			for (int i = 1; i < DEPTH; i++)
				stage[i] <= stage[i-1];
		end
	end

	// Tail of the chain
	assign q = stage[DEPTH-1];

endmodule

/* verilog/udp_rx_parser.sv */
// Receive stage: frame start detect, enable gating and byte position tagging
`timescale 1ns/1ps
`include "udp_params.svh"

module udp_rx_parser (
	input clk,
	input arst_n,
	input [7:0] rxd,
	input rx_dv,
	input enable_rx,
	output udp_pkg::beat_t beat
);

	logic rx_dv_d;
	logic keep_r;
	logic [2:0] pos_r;
	logic sof;
	logic keep;
	logic [2:0] pos;

	// Frame starts on rising rx_dv
	assign sof = rx_dv && !rx_dv_d;
	// Enable only sampled at frame start
	assign keep = sof ? enable_rx : keep_r;
	// Position restarts at sof
	assign pos = sof ? 3'd0 : pos_r;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_dv_d <= 1'b0;
			keep_r <= 1'b0;
			pos_r <= 3'd0;
		end else begin
			rx_dv_d <= rx_dv;
			if (rx_dv) begin
				keep_r <= keep;
				// Stick at payload position
				if (pos < 3'(`UDP_HDR_LEN))
					pos_r <= pos + 3'd1;
				else
					pos_r <= pos;
			end
		end
	end

	// Registered beat out, match fields left clear
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			beat <= '0;
		end else begin
			beat.valid <= rx_dv && keep;
			beat.data <= rxd;
			beat.sof <= sof;
			beat.pos <= pos;
			beat.hit <= 1'b0;
			beat.slot <= '0;
		end
	end

endmodule

/* verilog/udp_port_match.sv */
// Port table, destination port lookup and per-frame slot tagging
`timescale 1ns/1ps
`include "udp_params.svh"

module udp_port_match (
	input clk,
	input arst_n,
	input udp_pkg::cfg_t cfg,
	input udp_pkg::beat_t in_beat,
	output udp_pkg::beat_t out_beat
);

	logic [15:0] port_tab [`UDP_N_SLOTS];
	logic [7:0] dst_hi;
	logic hit_r;
	udp_pkg::slot_t slot_r;
	logic find_hit;
	udp_pkg::slot_t find_slot;
	logic at_pos3;

	// Low destination byte arrives here
	assign at_pos3 = in_beat.valid && in_beat.pos == 3'd3;

	// Table write lands on the strobe edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			port_tab[0] <= `UDP_PORT0;
			port_tab[1] <= `UDP_PORT1;
			port_tab[2] <= `UDP_PORT2;
			port_tab[3] <= `UDP_PORT3;
		end else if (cfg.stb) begin
			port_tab[cfg.addr] <= cfg.port;
		end
	end

	// High destination byte
	always_ff @(posedge clk) begin
		if (in_beat.valid && in_beat.pos == 3'd2)
			dst_hi <= in_beat.data;
	end

	// Walk down so the lowest matching slot wins; port 0 means slot off
	always_comb begin
		find_hit = 1'b0;
		find_slot = '0;
		for (int i = `UDP_N_SLOTS - 1; i >= 0; i--) begin
			if (port_tab[i] != 16'd0 && port_tab[i] == {dst_hi, in_beat.data}) begin
				find_hit = 1'b1;
				find_slot = udp_pkg::slot_t'(i);
			end
		end
	end

	// Verdict held for the payload
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hit_r <= 1'b0;
			slot_r <= '0;
		end else if (in_beat.valid && in_beat.sof) begin
			hit_r <= 1'b0;
			slot_r <= '0;
		end else if (at_pos3) begin
			hit_r <= find_hit;
			slot_r <= find_slot;
		end
	end

	// Tag position 3 onward
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_beat <= '0;
		end else begin
			out_beat <= in_beat;
			if (at_pos3) begin
				out_beat.hit <= find_hit;
				out_beat.slot <= find_slot;
			end else if (in_beat.pos > 3'd3) begin
				out_beat.hit <= hit_r;
				out_beat.slot <= slot_r;
			end
		end
	end

endmodule

/* verilog/udp_client_pipe.sv */
// Fixed-latency client pipeline applying the per-slot payload transform
`timescale 1ns/1ps
`include "udp_params.svh"

module udp_client_pipe (
	input clk,
	input arst_n,
	input udp_pkg::beat_t in_beat,
	output udp_pkg::beat_t out_beat
);

	udp_pkg::beat_t dly;

	// Client latency lives in the chain
	beat_delay #(
		.payload_t(udp_pkg::beat_t),
		.DEPTH(`UDP_N_LAT)
	) u_dly (
		.clk(clk),
		.arst_n(arst_n),
		.d(in_beat),
		.q(dly)
	);

	// Transform picked by slot
	function automatic logic [7:0] xform(input udp_pkg::slot_t slot, input logic [7:0] d);
		logic [7:0] r;
		r = d;
		case (udp_pkg::xform_e'(slot))
			udp_pkg::XF_ECHO: r = d;
			udp_pkg::XF_INV: r = ~d;
			// Wraps at 256
			udp_pkg::XF_INC: r = d + 8'd1;
			udp_pkg::XF_REV: begin
				for (int i = 0; i < 8; i++)
					r[i] = d[7-i];
			end
			default: r = d;
		endcase
		return r;
	endfunction

	// Header beats untouched
	always_comb begin
		out_beat = dly;
		if (dly.valid && dly.pos == 3'(`UDP_HDR_LEN))
			out_beat.data = xform(dly.slot, dly.data);
	end

endmodule

/* verilog/udp_tx_framer.sv */
// Reply framer: port swap, short and unmatched frame drop, GMII-style output
`timescale 1ns/1ps
`include "udp_params.svh"

module udp_tx_framer (
	input clk,
	input arst_n,
	input udp_pkg::beat_t in_beat,
	output [7:0] txd,
	output tx_en
);

	udp_pkg::beat_t win_q;
	logic [7:0] hdr [`UDP_HDR_LEN];
	logic hdr_hit;
	logic long_enough;
	logic keep_r;
	logic keep;

	// Window spans the header
	beat_delay #(
		.payload_t(udp_pkg::beat_t),
		.DEPTH(`UDP_HDR_LEN)
	) u_win (
		.clk(clk),
		.arst_n(arst_n),
		.d(in_beat),
		.q(win_q)
	);

	// Header bytes as they enter
	always_ff @(posedge clk) begin
		if (in_beat.valid && in_beat.pos < 3'(`UDP_HDR_LEN))
			hdr[in_beat.pos[1:0]] <= in_beat.data;
	end

	// Match verdict from position 3
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			hdr_hit <= 1'b0;
		else if (in_beat.valid && in_beat.sof)
			hdr_hit <= 1'b0;
		else if (in_beat.valid && in_beat.pos == 3'd3)
			hdr_hit <= in_beat.hit;
	end

	// Payload entering as byte 0 leaves, so 5 bytes or more
	assign long_enough = in_beat.valid && in_beat.pos == 3'(`UDP_HDR_LEN);
	// Decided once, when byte 0 leaves
	assign keep = (win_q.valid && win_q.sof) ? (hdr_hit && long_enough) : keep_r;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			keep_r <= 1'b0;
		else if (win_q.valid && win_q.sof)
			keep_r <= keep;
	end

	assign tx_en = win_q.valid && keep;
	// Flip bit 1 of the index to swap source and destination
	assign txd = (win_q.pos < 3'(`UDP_HDR_LEN)) ? hdr[win_q.pos[1:0] ^ 2'd2] : win_q.data;

endmodule

/* verilog/udp_engine.sv */
// Top level: parser, port match, client pipeline and reply framer in a chain
`timescale 1ns/1ps

module udp_engine (
	input clk,
	input arst_n,
	// GMII-style receive
	input [7:0] rxd,
	input rx_dv,
	input enable_rx,
	// Port table write
	input udp_pkg::cfg_t cfg,
	// GMII-style transmit
	output [7:0] txd,
	output tx_en
);

	udp_pkg::beat_t rx_beat;
	udp_pkg::beat_t match_beat;
	udp_pkg::beat_t client_beat;

	udp_rx_parser u_parser (
		.clk(clk),
		.arst_n(arst_n),
		.rxd(rxd),
		.rx_dv(rx_dv),
		.enable_rx(enable_rx),
		.beat(rx_beat)
	);

	udp_port_match u_match (
		.clk(clk),
		.arst_n(arst_n),
		.cfg(cfg),
		.in_beat(rx_beat),
		.out_beat(match_beat)
	);

	udp_client_pipe u_client (
		.clk(clk),
		.arst_n(arst_n),
		.in_beat(match_beat),
		.out_beat(client_beat)
	);

	udp_tx_framer u_framer (
		.clk(clk),
		.arst_n(arst_n),
		.in_beat(client_beat),
		.txd(txd),
		.tx_en(tx_en)
	);

endmodule

/* testbench/udp_engine_chk.sv */
// Bound concurrent checks on reset quiet and rxd to txd latency of the engine
`timescale 1ns/1ps
`include "udp_params.svh"

module udp_engine_chk (
	input clk,
	input arst_n,
	input rx_dv,
	input tx_en
);

	// No reply while reset is held
	a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !tx_en)
		else $error("tx_en high during reset");

	// First cycle out of reset
	a_release_quiet: assert property (@(posedge clk) $rose(arst_n) |-> !tx_en)
		else $error("tx_en high right after reset release");

	// Every tx beat traces back to an rx beat
	a_beat_latency: assert property (@(posedge clk) disable iff (!arst_n)
		tx_en |-> $past(rx_dv, `UDP_LAT))
		else $error("tx_en without rx_dv %0d cycles earlier", `UDP_LAT);

	// Reply start lines up with a frame start
	a_start_latency: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(tx_en) |-> $past(rx_dv, `UDP_LAT) && !$past(rx_dv, `UDP_LAT + 1))
		else $error("tx_en rose without a rising rx_dv %0d cycles earlier", `UDP_LAT);

endmodule

bind udp_engine udp_engine_chk u_chk (
	.clk(clk),
	.arst_n(arst_n),
	.rx_dv(rx_dv),
	.tx_en(tx_en)
);

/* testbench/udp_engine_tb.sv */
// Engine testbench: clock, reset, LFSR stimulus, reply model, output checks and report
`timescale 1ns/1ps
`include "udp_params.svh"

module udp_engine_tb;

	// Frames over all tests, sizes the watchdog
	localparam int N_FRAMES = 27;

	logic clk;
	logic arst_n;
	logic [7:0] rxd;
	logic rx_dv;
	logic enable_rx;
	udp_pkg::cfg_t cfg;
	logic [7:0] txd;
	logic tx_en;

	logic [31:0] lfsr;
	// Model copy of the port table
	logic [15:0] model_ports [`UDP_N_SLOTS];
	// Reply bytes still to come out
	logic [7:0] exp_q [$];
	int exp_frames;
	int tx_frames;
	int frame_mark;
	int mon_errors;
	int chk_errors;
	int err_mark;
	int tests_passed;
	int tests_failed;
	logic tx_en_d = 1'b0;

	udp_engine DUT (
		.clk(clk),
		.arst_n(arst_n),
		.rxd(rxd),
		.rx_dv(rx_dv),
		.enable_rx(enable_rx),
		.cfg(cfg),
		.txd(txd),
		.tx_en(tx_en)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic next_rand_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	// One LFSR step per bit
	function automatic int rand_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++)
			r = (r << 1) | int'(next_rand_bit());
		return r;
	endfunction

	// Slot transforms: echo, invert, +1, bit reverse
	function automatic logic [7:0] xform_ref(input int s, input logic [7:0] d);
		case (s)
			0: return d;
			1: return ~d;
			2: return d + 8'd1;
			default: return {<<{d}};
		endcase
	endfunction

	// Reply bytes checked against the model queue, mid-cycle where outputs are settled
	always @(negedge clk) begin
		if (arst_n && tx_en) begin
			assert (exp_q.size() > 0) else begin
				$display("Unexpected tx beat at %0t while no reply was due", $time);
				mon_errors++;
			end
			if (exp_q.size() > 0) begin
				assert (txd == exp_q[0]) else begin
					$display("MISMATCH at %0t: expected %02h, got %02h", $time, exp_q[0], txd);
					mon_errors++;
				end
				void'(exp_q.pop_front());
			end
		end
		// Reply frame starts
		if (tx_en && !tx_en_d)
			tx_frames++;
		tx_en_d <= tx_en;
	end

	// Watchdog, 4 x latency + 80 cycles per frame
	initial begin
		repeat (N_FRAMES * (4 * `UDP_LAT + 80)) @(posedge clk);
		$display("Timeout: the run did not finish within its cycle budget");
		$display("CHECKS FAILED");
		$finish;
	end

	// Model prediction, then one byte per falling edge and one idle cycle
	task automatic send_frame(input logic [15:0] src, input logic [15:0] dst, input int len,
		input int raise_at);
		logic [7:0] hdr [4];
		logic [7:0] b;
		int slot;
		logic kept;
		hdr[0] = src[15:8];
		hdr[1] = src[7:0];
		hdr[2] = dst[15:8];
		hdr[3] = dst[7:0];
		// First enabled slot that matches
		slot = -1;
		for (int s = 0; s < `UDP_N_SLOTS; s++)
			if (slot < 0 && model_ports[s] != 16'd0 && model_ports[s] == dst)
				slot = s;
		kept = enable_rx && len > `UDP_HDR_LEN && slot >= 0;
		if (kept) begin
			// Destination first in the reply
			exp_q.push_back(hdr[2]);
			exp_q.push_back(hdr[3]);
			exp_q.push_back(hdr[0]);
			exp_q.push_back(hdr[1]);
			exp_frames++;
		end
		for (int i = 0; i < len; i++) begin
			@(negedge clk);
			if (i < `UDP_HDR_LEN) begin
				b = hdr[i];
			end else begin
				b = 8'(rand_bits(8));
				if (kept)
					exp_q.push_back(xform_ref(slot, b));
			end
			rxd = b;
			rx_dv = 1'b1;
			// Late enable, frame stays dropped
			if (i == raise_at)
				enable_rx = 1'b1;
		end
		@(negedge clk);
		rx_dv = 1'b0;
		rxd = 8'h00;
	endtask

	task automatic write_port(input udp_pkg::slot_t slot, input logic [15:0] port);
		@(negedge clk);
		cfg.stb = 1'b1;
		cfg.addr = slot;
		cfg.port = port;
		model_ports[slot] = port;
		@(negedge clk);
		cfg = '0;
	endtask

	// Drain, check leftovers and frame count, one line per test
	task automatic end_test(input int num, input string name);
		int errs;
		repeat (`UDP_LAT + 2) @(negedge clk);
		assert (exp_q.size() == 0) else begin
			$display("Test %0d: %0d reply bytes never came out", num, exp_q.size());
			chk_errors++;
		end
		assert (tx_frames - frame_mark == exp_frames) else begin
			$display("MISMATCH at %0t: test %0d saw %0d reply frames, expected %0d", $time,
				num, tx_frames - frame_mark, exp_frames);
			chk_errors++;
		end
		errs = mon_errors + chk_errors - err_mark;
		if (errs == 0) begin
			tests_passed++;
			$display("Test %0d %s: ok", num, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: %0d errors", num, name, errs);
		end
		exp_q.delete();
		exp_frames = 0;
		frame_mark = tx_frames;
		err_mark = mon_errors + chk_errors;
	endtask

	initial begin
		int len;
		logic [15:0] dst;
		lfsr = 32'ha204;
		arst_n = 1'b0;
		rxd = 8'h00;
		rx_dv = 1'b0;
		enable_rx = 1'b1;
		cfg = '0;
		model_ports[0] = `UDP_PORT0;
		model_ports[1] = `UDP_PORT1;
		model_ports[2] = `UDP_PORT2;
		model_ports[3] = `UDP_PORT3;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// Idle line after reset
		repeat (20) @(negedge clk);
		end_test(1, "idle after reset");

		// Two frames per default port
		for (int i = 0; i < 8; i++) begin
			len = 5 + rand_bits(6) % 36;
			send_frame(16'(rand_bits(16)), model_ports[i % 4], len, -1);
		end
		end_test(2, "default port transforms");

		// Unlisted port, then 1 to 4 byte frames
		for (int i = 0; i < 2; i++) begin
			len = 5 + rand_bits(6) % 36;
			send_frame(16'(rand_bits(16)), 16'd900, len, -1);
		end
		for (int i = 1; i <= 4; i++)
			send_frame(16'(rand_bits(16)), model_ports[i - 1], i, -1);
		end_test(3, "unlisted port and short frames");

		// Slot 2 moves, slot 1 switched off
		write_port(2'd2, 16'd1234);
		send_frame(16'd55, 16'd802, 12, -1);
		send_frame(16'd56, 16'd1234, 12, -1);
		write_port(2'd1, 16'd0);
		send_frame(16'd57, 16'd801, 12, -1);
		send_frame(16'd58, 16'd7, 12, -1);
		end_test(4, "port table writes");

		// Enable low at frame start, raised mid-frame
		@(negedge clk);
		enable_rx = 1'b0;
		send_frame(16'd60, 16'd7, 10, -1);
		send_frame(16'd61, 16'd803, 10, 2);
		send_frame(16'd62, 16'd803, 10, -1);
		end_test(5, "receive enable gating");

		// Back to back with one idle cycle
		for (int i = 0; i < 6; i++) begin
			dst = (i % 3 == 0) ? model_ports[0] : model_ports[i % 3 + 1];
			len = 5 + rand_bits(6) % 36;
			send_frame(16'(rand_bits(16)), dst, len, -1);
		end
		end_test(6, "back-to-back frames");

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* files.f */
+incdir+verilog
verilog/udp_pkg.sv
verilog/beat_delay.sv
verilog/udp_rx_parser.sv
verilog/udp_port_match.sv
verilog/udp_client_pipe.sv
verilog/udp_tx_framer.sv
verilog/udp_engine.sv
testbench/udp_engine_chk.sv
testbench/udp_engine_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the UDP engine testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module udp_engine_tb -o udp_engine_sim

# A failing bound assertion stops the run with a nonzero status
./obj_dir/udp_engine_sim 2>&1 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation reported failures, see sim.log"
	exit 1
fi
echo "Simulation finished without failures"
